// ==== bench/fetch_unit_assertions.sv ====
`timescale 1ns/10ps

module fetch_unit_assertions (
   input logic             clk,
   input logic             rst_n,
   input fetch_pkg::bcnt_t bcnt,
   input logic             stall_jump,
   input logic             stall_fetch,
   input fetch_pkg::inst_t inst0,
   input fetch_pkg::inst_t inst1,
   input fetch_pkg::inst_t inst2,
   input fetch_pkg::inst_t inst3,
   input fetch_pkg::inst_t slot_inst0,
   input fetch_pkg::inst_t slot_inst1,
   input fetch_pkg::inst_t slot_inst2,
   input fetch_pkg::inst_t slot_inst3
);

   // failed assertions so far
   int fail_count = 0;

   // slot whose raw word was replaced by a nop
   logic [2:0] nopped;

   assign nopped[0] = (slot_inst0 == '0) && (inst0 != '0);
   assign nopped[1] = (slot_inst1 == '0) && (inst1 != '0);
   assign nopped[2] = (slot_inst2 == '0) && (inst2 != '0);

   // unresolved count stays within limit
   count_limit: assert property (@(posedge clk) disable iff (!rst_n)
      bcnt <= fetch_pkg::max_branches)
      else begin
         $error("branch count above limit");
         fail_count++;
      end

   // no issued word after a nopped slot
   flush_chain: assert property (@(posedge clk) disable iff (!rst_n)
      !(nopped[0] && (slot_inst1 != '0 || slot_inst2 != '0 || slot_inst3 != '0)) &&
      !(nopped[1] && (slot_inst2 != '0 || slot_inst3 != '0)) &&
      !(nopped[2] && slot_inst3 != '0))
      else begin
         $error("flushed slot followed by an issued slot");
         fail_count++;
      end

   // stall nops the whole group
   stall_zero: assert property (@(posedge clk) disable iff (!rst_n)
      (stall_jump || stall_fetch) |->
         (slot_inst0 == '0 && slot_inst1 == '0 && slot_inst2 == '0 && slot_inst3 == '0))
      else begin
         $error("slot issued during stall");
         fail_count++;
      end

endmodule

// ==== bench/fetch_unit_tb.sv ====
`timescale 1ns/10ps

module fetch_unit_tb;

   localparam int rom_words = 256;
   localparam int ctr_words = 16;
   localparam int n_steps   = 31;
   localparam int seed      = 99751;

   logic             clk;
   logic             rst_n;
   logic             load_en;
   fetch_pkg::pc_t   load_addr;
   fetch_pkg::inst_t load_data;
   logic             stall_jump;
   logic             stall_fetch;
   logic             commit_strobe;
   logic             mispred_two;
   logic             resolve_valid;
   fetch_pkg::pc_t   resolve_pc;
   logic             resolve_taken;
   logic             redirect_valid;
   fetch_pkg::pc_t   redirect_pc;
   fetch_pkg::pc_t   fetch_pc;
   fetch_pkg::inst_t slot_inst0;
   fetch_pkg::inst_t slot_inst1;
   fetch_pkg::inst_t slot_inst2;
   fetch_pkg::inst_t slot_inst3;
   logic [3:0]       imm_jump;
   logic             update_bpred;

   // ctl bits are {stall_jump, stall_fetch, commit, mispred_two, resolve_valid}
   string            row_name [n_steps];
   logic [4:0]       row_ctl [n_steps];
   fetch_pkg::pc_t   row_res_pc [n_steps];
   logic             row_res_taken [n_steps];
   logic             row_redir [n_steps];
   fetch_pkg::pc_t   row_redir_pc [n_steps];
   fetch_pkg::pc_t   row_exp_pc [n_steps];

   // reference model state
   fetch_pkg::inst_t prog [rom_words];
   fetch_pkg::ctr_t  m_ctr [ctr_words];
   int               m_bcnt;
   fetch_pkg::pc_t   m_pc;
   fetch_pkg::pc_t   m_pc_next;
   int               m_new_br;

   // expected group outputs for the current step
   fetch_pkg::inst_t exp_slot [4];
   logic [3:0]       exp_imm;
   logic             exp_upd;

   fetch_unit #(
      .ROM_DEPTH_LOG2   (8),
      .BPRED_INDEX_BITS (4)
   ) dut_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .load_en        (load_en),
      .load_addr      (load_addr),
      .load_data      (load_data),
      .stall_jump     (stall_jump),
      .stall_fetch    (stall_fetch),
      .commit_strobe  (commit_strobe),
      .mispred_two    (mispred_two),
      .resolve_valid  (resolve_valid),
      .resolve_pc     (resolve_pc),
      .resolve_taken  (resolve_taken),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .fetch_pc       (fetch_pc),
      .slot_inst0     (slot_inst0),
      .slot_inst1     (slot_inst1),
      .slot_inst2     (slot_inst2),
      .slot_inst3     (slot_inst3),
      .imm_jump       (imm_jump),
      .update_bpred   (update_bpred)
   );

   bind branch_handler fetch_unit_assertions assertions_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .bcnt        (bcnt),
      .stall_jump  (stall_jump),
      .stall_fetch (stall_fetch),
      .inst0       (inst0),
      .inst1       (inst1),
      .inst2       (inst2),
      .inst3       (inst3),
      .slot_inst0  (slot_inst0),
      .slot_inst1  (slot_inst1),
      .slot_inst2  (slot_inst2),
      .slot_inst3  (slot_inst3)
   );

   // 10 ns period
   always #5 clk = ~clk;

   ////////////////////
   // helpers
   ////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check_value(input string name, input string what,
                              input logic [15:0] expected, input logic [15:0] actual);
      if (actual !== expected) begin
         $display("error %s %s: expected %h, actual %h", name, what, expected, actual);
         $display("TEST FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic set_row(input int i, input string name, input logic [4:0] ctl,
                          input logic [15:0] res_pc, input logic res_taken,
                          input logic redir, input logic [15:0] redir_pc,
                          input logic [15:0] exp_pc);
      row_name[i]      = name;
      row_ctl[i]       = ctl;
      row_res_pc[i]    = res_pc;
      row_res_taken[i] = res_taken;
      row_redir[i]     = redir;
      row_redir_pc[i]  = redir_pc;
      row_exp_pc[i]    = exp_pc;
   endtask

   // filler words plus a few jumps and branches
   task automatic build_program();
      logic [31:0] r;
      r = 32'(seed);
      for (int a = 0; a < rom_words; a++) begin
         r = xorshift32(r);
         // msb clear is neither jump nor branch
         // lsb set keeps it off nop
         prog[a] = {1'b0, r[14:1], 1'b1};
      end
      // immediate jump in slot 2 of group 16
      prog[18] = 16'hf000;
      // register jump in slot 0 of group 20
      prog[20] = 16'hf003;
      // branch +16 to target 50
      prog[34] = 16'h9010;
      // three branches back to back
      prog[72] = 16'ha004;
      prog[73] = 16'hb004;
      prog[74] = 16'h9004;
   endtask

   task automatic build_table();
      //       step  name                   ctl      res_pc  tk    rd    rd_pc    pc
      set_row(0,  "straight_0",          5'b00000, 16'd0,  1'b0, 1'b0, 16'd0,   16'd0);
      set_row(1,  "straight_4",          5'b00000, 16'd0,  1'b0, 1'b0, 16'd0,   16'd4);
      set_row(2,  "straight_8",          5'b00000, 16'd0,  1'b0, 1'b0, 16'd0,   16'd8);
      set_row(3,  "straight_12",         5'b00000, 16'd0,  1'b0, 1'b0, 16'd0,   16'd12);
      set_row(4,  "jump_slot2",          5'b00000, 16'd0,  1'b0, 1'b0, 16'd0,   16'd16);
      set_row(5,  "jump_slot0",          5'b00000, 16'd0,  1'b0, 1'b0, 16'd0,   16'd20);
      set_row(6,  "jump_hold",           5'b00000, 16'd0,  1'b0, 1'b0, 16'd0,   16'd20);
      set_row(7,  "redirect_32",         5'b00000, 16'd0,  1'b0, 1'b1, 16'd32,  16'd20);
      set_row(8,  "branch_not_taken",    5'b00000, 16'd0,  1'b0, 1'b0, 16'd0,   16'd32);
      set_row(9,  "train_taken_1",       5'b00101, 16'd34, 1'b1, 1'b0, 16'd0,   16'd36);
      set_row(10, "train_taken_2",       5'b00001, 16'd34, 1'b1, 1'b0, 16'd0,   16'd40);
      set_row(11, "redirect_back",       5'b00000, 16'd0,  1'b0, 1'b1, 16'd32,  16'd44);
      set_row(12, "branch_taken",        5'b00000, 16'd0,  1'b0, 1'b0, 16'd0,   16'd32);
      set_row(13, "after_taken",         5'b00100, 16'd0,  1'b0, 1'b0, 16'd0,   16'd50);
      set_row(14, "redirect_72",         5'b00000, 16'd0,  1'b0, 1'b1, 16'd72,  16'd54);
      set_row(15, "three_branches",      5'b00000, 16'd0,  1'b0, 1'b0, 16'd0,   16'd72);
      set_row(16, "limit_hold",          5'b00000, 16'd0,  1'b0, 1'b0, 16'd0,   16'd74);
      set_row(17, "commit_one",          5'b00100, 16'd0,  1'b0, 1'b0, 16'd0,   16'd74);
      set_row(18, "partial_fetch",       5'b00000, 16'd0,  1'b0, 1'b0, 16'd0,   16'd74);
      set_row(19, "commit_two",          5'b00110, 16'd0,  1'b0, 1'b0, 16'd0,   16'd75);
      set_row(20, "resume",              5'b00000, 16'd0,  1'b0, 1'b0, 16'd0,   16'd75);
      set_row(21, "stall_fetch",         5'b01000, 16'd0,  1'b0, 1'b0, 16'd0,   16'd79);
      set_row(22, "stall_jump",          5'b10000, 16'd0,  1'b0, 1'b0, 16'd0,   16'd79);
      set_row(23, "resume_79",           5'b00000, 16'd0,  1'b0, 1'b0, 16'd0,   16'd79);
      set_row(24, "redirect_32b",        5'b00000, 16'd0,  1'b0, 1'b1, 16'd32,  16'd83);
      set_row(25, "redirect_over_taken", 5'b00000, 16'd0,  1'b0, 1'b1, 16'd100, 16'd32);
      set_row(26, "stall_redirect",      5'b01000, 16'd0,  1'b0, 1'b1, 16'd16,  16'd100);
      set_row(27, "jump_again",          5'b00000, 16'd0,  1'b0, 1'b0, 16'd0,   16'd16);
      set_row(28, "redirect_wrap",       5'b00000, 16'd0,  1'b0, 1'b1, 16'd254, 16'd20);
      set_row(29, "wrap",                5'b00000, 16'd0,  1'b0, 1'b0, 16'd0,   16'd254);
      set_row(30, "past_wrap",           5'b00000, 16'd0,  1'b0, 1'b0, 16'd0,   16'd258);
   endtask

   ////////////////////
   // reference model
   ////////////////////

   // group outputs and next pc for step i
   task automatic predict_cycle(input int i);
      fetch_pkg::inst_t w [4];
      logic             jmp [4];
      logic             br [4];
      logic             ov [4];
      logic             stall;
      logic             ended;
      logic             jump_seen;
      logic             took;
      logic             guess;
      logic             fl;
      int               cnt;
      int               seen;
      int               took_slot;
      int               step;
      fetch_pkg::pc_t   off;
      stall     = row_ctl[i][4] | row_ctl[i][3];
      cnt       = m_bcnt;
      seen      = 0;
      ended     = 1'b0;
      jump_seen = 1'b0;
      took      = 1'b0;
      took_slot = 0;
      exp_imm   = 4'b0000;
      exp_upd   = 1'b0;
      m_new_br  = 0;
      for (int k = 0; k < 4; k++) begin
         w[k]   = prog[(int'(m_pc) + k) % rom_words];
         jmp[k] = w[k][15:12] == 4'hf;
         br[k]  = (w[k][15:14] == 2'b10) && (w[k][13:12] != 2'b00);
         // over once older branches reach the limit
         ov[k]  = cnt >= 2;
         fl     = stall || ov[k] || ended;
         guess  = 1'b0;
         if (br[k]) begin
            // only the first two branches get a prediction
            if (seen < 2) begin
               guess = m_ctr[(int'(m_pc) + k) % ctr_words][1];
            end
            seen++;
            cnt++;
         end
         exp_slot[k]  = fl ? 16'h0000 : w[k];
         exp_imm[3-k] = jmp[k] && (w[k][1:0] == 2'b00) && !fl;
         if (jmp[k]) begin
            jump_seen = 1'b1;
         end else if (br[k] && !fl && !jump_seen) begin
            exp_upd = 1'b1;
         end
         if (br[k] && !fl) begin
            m_new_br++;
         end
         if (br[k] && guess && !fl && !took) begin
            took      = 1'b1;
            took_slot = k;
         end
         // younger slots die after a jump, a taken branch or a flush
         ended = fl || jmp[k] || (br[k] && guess && !fl);
      end
      if (stall || jmp[0]) begin
         step = 0;
      end else begin
         step = 4;
         for (int k = 3; k >= 0; k--) begin
            if (ov[k]) begin
               step = k;
            end
         end
      end
      if (row_redir[i]) begin
         m_pc_next = row_redir_pc[i];
      end else if (took) begin
         off       = {{8{w[took_slot][7]}}, w[took_slot][7:0]};
         m_pc_next = m_pc + fetch_pkg::pc_t'(took_slot) + off;
      end else begin
         m_pc_next = m_pc + fetch_pkg::pc_t'(step);
      end
   endtask

   // state update at the clock edge ending step i
   task automatic advance_model(input int i);
      int idx;
      if (row_ctl[i][2] && m_bcnt != 0) begin
         if (row_ctl[i][1]) begin
            m_bcnt = (m_bcnt >= 2) ? m_bcnt - 2 : 0;
         end else begin
            m_bcnt = m_bcnt - 1;
         end
      end else begin
         m_bcnt = (m_bcnt + m_new_br > 2) ? 2 : m_bcnt + m_new_br;
      end
      if (row_ctl[i][0]) begin
         idx = int'(row_res_pc[i]) % ctr_words;
         if (row_res_taken[i] && m_ctr[idx] != 2'b11) begin
            m_ctr[idx] = m_ctr[idx] + 2'b01;
         end else if (!row_res_taken[i] && m_ctr[idx] != 2'b00) begin
            m_ctr[idx] = m_ctr[idx] - 2'b01;
         end
      end
      m_pc = m_pc_next;
   endtask

   ////////////////////
   // main sequence
   ////////////////////

   initial begin
      clk            = 1'b0;
      rst_n          = 1'b0;
      load_en        = 1'b0;
      load_addr      = '0;
      load_data      = '0;
      stall_jump     = 1'b0;
      // pc holds while the program loads
      stall_fetch    = 1'b1;
      commit_strobe  = 1'b0;
      mispred_two    = 1'b0;
      resolve_valid  = 1'b0;
      resolve_pc     = '0;
      resolve_taken  = 1'b0;
      redirect_valid = 1'b0;
      redirect_pc    = '0;
      build_program();
      build_table();
      m_bcnt = 0;
      m_pc   = '0;
      for (int e = 0; e < ctr_words; e++) begin
         m_ctr[e] = 2'b01;
      end
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      // one word per edge
      for (int a = 0; a < rom_words; a++) begin
         @(posedge clk);
         load_en   <= 1'b1;
         load_addr <= fetch_pkg::pc_t'(a);
         load_data <= prog[a];
      end
      @(posedge clk);
      load_en <= 1'b0;
      for (int i = 0; i < n_steps; i++) begin
         @(posedge clk);
         stall_jump     <= row_ctl[i][4];
         stall_fetch    <= row_ctl[i][3];
         commit_strobe  <= row_ctl[i][2];
         mispred_two    <= row_ctl[i][1];
         resolve_valid  <= row_ctl[i][0];
         resolve_pc     <= row_res_pc[i];
         resolve_taken  <= row_res_taken[i];
         redirect_valid <= row_redir[i];
         redirect_pc    <= row_redir_pc[i];
         // outputs settled mid cycle
         @(negedge clk);
         predict_cycle(i);
         check_value(row_name[i], "fetch_pc", row_exp_pc[i], fetch_pc);
         check_value(row_name[i], "slot_inst0", exp_slot[0], slot_inst0);
         check_value(row_name[i], "slot_inst1", exp_slot[1], slot_inst1);
         check_value(row_name[i], "slot_inst2", exp_slot[2], slot_inst2);
         check_value(row_name[i], "slot_inst3", exp_slot[3], slot_inst3);
         check_value(row_name[i], "imm_jump", {12'd0, exp_imm}, {12'd0, imm_jump});
         check_value(row_name[i], "update_bpred", {15'd0, exp_upd}, {15'd0, update_bpred});
         advance_model(i);
      end
      @(posedge clk);
      @(negedge clk);
      $display("TEST PASS");
      $finish;
   end

   // bound checks on the branch handler
   initial begin
      wait (dut_i.handler_i.assertions_i.fail_count != 0);
      $display("a bound assertion on the branch handler failed");
      $display("TEST FAIL");
      $fatal(1, "assertion failure");
   end

   // reset, load and table plus margin
   initial begin
      #((4 + rom_words + n_steps + 20) * 10);
      $display("watchdog expired before the test sequence finished");
      $display("TEST FAIL");
      $fatal(1, "timeout");
   end

endmodule

// ==== rtl/branch_handler.sv ====
`timescale 1ns/10ps

module branch_handler (
   input  logic             clk,
   input  logic             rst_n,
   input  fetch_pkg::pc_t   pc,
   input  fetch_pkg::inst_t inst0,
   input  fetch_pkg::inst_t inst1,
   input  fetch_pkg::inst_t inst2,
   input  fetch_pkg::inst_t inst3,
   input  logic             stall_jump,
   input  logic             stall_fetch,
   input  logic [1:0]       pred,
   input  logic             commit_strobe,
   input  logic             mispred_two,
   output logic [1:0]       first_slot,
   output logic [1:0]       second_slot,
   output logic             update_bpred,
   output fetch_pkg::inst_t slot_inst0,
   output fetch_pkg::inst_t slot_inst1,
   output fetch_pkg::inst_t slot_inst2,
   output fetch_pkg::inst_t slot_inst3,
   output logic [3:0]       imm_jump,
   output logic [2:0]       pc_step,
   output logic             taken_valid,
   output logic [1:0]       taken_slot,
   output fetch_pkg::inst_t taken_inst
);

   fetch_pkg::inst_t inst [4];
   fetch_pkg::bcnt_t bcnt;
   fetch_pkg::bcnt_t bcnt_next;

   logic [3:0] is_jump;
   logic [3:0] is_branch;
   logic [3:0] over;
   logic [3:0] guess;
   logic [3:0] taken;
   logic [3:0] flush;
   // count before each slot, 3 bits so it cannot wrap
   logic [2:0] cnt_before [4];
   logic [2:0] new_branches;
   logic [2:0] cnt_sum;

   assign inst[0] = inst0;
   assign inst[1] = inst1;
   assign inst[2] = inst2;
   assign inst[3] = inst3;

   ////////////////////
   // slot decode
   ////////////////////

   always_comb begin
      for (int k = 0; k < 4; k++) begin
         is_jump[k]   = inst[k][15:12] == fetch_pkg::jump_op;
         is_branch[k] = (inst[k][15:14] == fetch_pkg::branch_op_hi) &&
                        (inst[k][13:12] != 2'b00);
      end
   end

   // running count, slot k over limit once count reaches max
   always_comb begin
      cnt_before[0] = {1'b0, bcnt};
      for (int k = 1; k < 4; k++) begin
         cnt_before[k] = cnt_before[k-1] + {2'b00, is_branch[k-1]};
      end
      for (int k = 0; k < 4; k++) begin
         over[k] = cnt_before[k] >= {1'b0, fetch_pkg::max_branches};
      end
   end

   // slot numbers of first and second branch, 0 when absent
   always_comb begin : branch_pick
      logic [1:0] seen;
      seen        = 2'd0;
      first_slot  = 2'd0;
      second_slot = 2'd0;
      guess       = 4'b0000;
      for (int k = 0; k < 4; k++) begin
         if (is_branch[k]) begin
            if (seen == 2'd0) begin
               first_slot = 2'(k);
               guess[k]   = pred[1];
            end else if (seen == 2'd1) begin
               second_slot = 2'(k);
               guess[k]    = pred[0];
            end
            // third and later are always over the limit
            if (seen != 2'd2) begin
               seen = seen + 2'd1;
            end
         end
      end
   end

   ////////////////////
   // flush chain
   ////////////////////

   // stall, over limit, or anything ending the group earlier
   always_comb begin
      flush[0] = stall_jump | stall_fetch | over[0];
      taken[0] = is_branch[0] & guess[0] & ~flush[0];
      for (int k = 1; k < 4; k++) begin
         flush[k] = stall_jump | stall_fetch | over[k] |
                    flush[k-1] | is_jump[k-1] | taken[k-1];
         taken[k] = is_branch[k] & guess[k] & ~flush[k];
      end
   end

   // nop out flushed slots
   assign slot_inst0 = flush[0] ? '0 : inst0;
   assign slot_inst1 = flush[1] ? '0 : inst1;
   assign slot_inst2 = flush[2] ? '0 : inst2;
   assign slot_inst3 = flush[3] ? '0 : inst3;

   // immediate jumps among issued slots, bit 3 is slot 0
   always_comb begin
      for (int k = 0; k < 4; k++) begin
         imm_jump[3-k] = is_jump[k] & (inst[k][1:0] == 2'b00) & ~flush[k];
      end
   end

   // predictor update: issued branch ahead of any jump
   always_comb begin : bpred_scan
      logic jump_seen;
      jump_seen    = 1'b0;
      update_bpred = 1'b0;
      for (int k = 0; k < 4; k++) begin
         if (is_jump[k]) begin
            jump_seen = 1'b1;
         end else if (is_branch[k] && !flush[k] && !jump_seen) begin
            update_bpred = 1'b1;
         end
      end
   end

   ////////////////////
   // next pc hints
   ////////////////////

   // at most one taken bit survives the chain
   assign taken_valid = |taken;
   assign taken_slot  = taken[0] ? 2'd0 :
                        taken[1] ? 2'd1 :
                        taken[2] ? 2'd2 : 2'd3;
   assign taken_inst  = taken_valid ? inst[taken_slot] : '0;

   // step stops at first over-limit slot
   always_comb begin
      if (stall_jump || stall_fetch || is_jump[0] || over[0]) begin
         pc_step = 3'd0;
      end else if (over[1]) begin
         pc_step = 3'd1;
      end else if (over[2]) begin
         pc_step = 3'd2;
      end else if (over[3]) begin
         pc_step = 3'd3;
      end else begin
         pc_step = 3'd4;
      end
   end

   ////////////////////
   // branch counter
   ////////////////////

   always_comb begin
      new_branches = 3'd0;
      for (int k = 0; k < 4; k++) begin
         new_branches = new_branches + {2'b00, is_branch[k] & ~flush[k]};
      end
      cnt_sum = {1'b0, bcnt} + new_branches;
      // saturate at limit
      if (cnt_sum >= {1'b0, fetch_pkg::max_branches}) begin
         bcnt_next = fetch_pkg::max_branches;
      end else begin
         bcnt_next = fetch_pkg::bcnt_t'(cnt_sum);
      end
   end

   // commit wins over new branches in the same cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bcnt <= '0;
      end else if (commit_strobe && bcnt != '0) begin
         if (!mispred_two) begin
            bcnt <= bcnt - 2'd1;
         end else if (bcnt >= 2'd2) begin
            bcnt <= bcnt - 2'd2;
         end else begin
            bcnt <= '0;
         end
      end else begin
         bcnt <= bcnt_next;
      end
   end

endmodule

// ==== rtl/branch_predictor.sv ====
`timescale 1ns/10ps

module branch_predictor #(
   parameter int BPRED_INDEX_BITS = 4
) (
   input  logic           clk,
   input  logic           rst_n,
   input  fetch_pkg::pc_t pc,
   input  logic [1:0]     first_slot,
   input  logic [1:0]     second_slot,
   input  logic           resolve_valid,
   input  fetch_pkg::pc_t resolve_pc,
   input  logic           resolve_taken,
   output logic [1:0]     pred
);

   localparam int ENTRIES = 1 << BPRED_INDEX_BITS;

   typedef logic [BPRED_INDEX_BITS-1:0] idx_t;

   // counter table
   fetch_pkg::ctr_t ctr [ENTRIES];

   fetch_pkg::pc_t first_pc;
   fetch_pkg::pc_t second_pc;
   idx_t first_idx;
   idx_t second_idx;
   idx_t train_idx;

   ////////////////////
   // lookup
   ////////////////////

   // pc of each branch = group pc + slot
   assign first_pc  = pc + fetch_pkg::pc_t'(first_slot);
   assign second_pc = pc + fetch_pkg::pc_t'(second_slot);

   // low pc bits pick the entry
   assign first_idx  = idx_t'(first_pc);
   assign second_idx = idx_t'(second_pc);
   assign train_idx  = idx_t'(resolve_pc);

   // bit 1 first branch, bit 0 second, counter msb is the guess
   assign pred = {ctr[first_idx][1], ctr[second_idx][1]};

   ////////////////////
   // training
   ////////////////////

   // up on taken, down on not taken, saturating
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < ENTRIES; i++) begin
            // weakly not taken
            ctr[i] <= 2'b01;
         end
      end else if (resolve_valid) begin
         if (resolve_taken) begin
            if (ctr[train_idx] != 2'b11) begin
               ctr[train_idx] <= ctr[train_idx] + 2'b01;
            end
         end else begin
            if (ctr[train_idx] != 2'b00) begin
               ctr[train_idx] <= ctr[train_idx] - 2'b01;
            end
         end
      end
   end

endmodule

// ==== rtl/fetch_pc_gen.sv ====
`timescale 1ns/10ps

module fetch_pc_gen (
   input  logic             clk,
   input  logic             rst_n,
   input  logic [2:0]       pc_step,
   input  logic             taken_valid,
   input  logic [1:0]       taken_slot,
   input  fetch_pkg::inst_t taken_inst,
   input  logic             redirect_valid,
   input  fetch_pkg::pc_t   redirect_pc,
   output fetch_pkg::pc_t   pc
);

   fetch_pkg::pc_t branch_pc;
   fetch_pkg::pc_t offset;
   fetch_pkg::pc_t target;
   fetch_pkg::pc_t next_pc;

   ////////////////////
   // branch target
   ////////////////////

   // pc of the taken branch itself
   assign branch_pc = pc + fetch_pkg::pc_t'(taken_slot);

   // signed 8-bit offset in low byte
   assign offset = {{8{taken_inst[7]}}, taken_inst[7:0]};

   assign target = branch_pc + offset;

   ////////////////////
   // next pc
   ////////////////////

   // redirect, then taken branch, then sequential step
   always_comb begin
      if (redirect_valid) begin
         next_pc = redirect_pc;
      end else if (taken_valid) begin
         next_pc = target;
      end else begin
         next_pc = pc + fetch_pkg::pc_t'(pc_step);
      end
   end

   // fetch pc register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= '0;
      end else begin
         pc <= next_pc;
      end
   end

endmodule

// ==== rtl/fetch_pkg.sv ====
package fetch_pkg;

   ////////////////////
   // widths
   ////////////////////

   // one 16-bit instruction word
   typedef logic [15:0] inst_t;

   // word address into instruction memory
   typedef logic [15:0] pc_t;

   // unresolved branches in flight, saturates at max_branches
   typedef logic [1:0] bcnt_t;

   // two-bit saturating predictor counter
   typedef logic [1:0] ctr_t;

   ////////////////////
   // opcode fields
   ////////////////////

   // jump when top nibble is all ones
   localparam logic [3:0] jump_op = 4'hf;

   // branch when top two bits match and bits 13:12 nonzero
   localparam logic [1:0] branch_op_hi = 2'b10;

   // limit on unresolved branches
   localparam bcnt_t max_branches = 2'd2;

endpackage

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit #(
   parameter int ROM_DEPTH_LOG2   = 8,
   parameter int BPRED_INDEX_BITS = 4
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             load_en,
   input  fetch_pkg::pc_t   load_addr,
   input  fetch_pkg::inst_t load_data,
   input  logic             stall_jump,
   input  logic             stall_fetch,
   input  logic             commit_strobe,
   input  logic             mispred_two,
   input  logic             resolve_valid,
   input  fetch_pkg::pc_t   resolve_pc,
   input  logic             resolve_taken,
   input  logic             redirect_valid,
   input  fetch_pkg::pc_t   redirect_pc,
   output fetch_pkg::pc_t   fetch_pc,
   output fetch_pkg::inst_t slot_inst0,
   output fetch_pkg::inst_t slot_inst1,
   output fetch_pkg::inst_t slot_inst2,
   output fetch_pkg::inst_t slot_inst3,
   output logic [3:0]       imm_jump,
   output logic             update_bpred
);

   // raw group from memory
   fetch_pkg::inst_t inst0;
   fetch_pkg::inst_t inst1;
   fetch_pkg::inst_t inst2;
   fetch_pkg::inst_t inst3;

   // predictor lookup
   logic [1:0] first_slot;
   logic [1:0] second_slot;
   logic [1:0] pred;

   // handler to pc generator
   logic [2:0]       pc_step;
   logic             taken_valid;
   logic [1:0]       taken_slot;
   fetch_pkg::inst_t taken_inst;

   ////////////////////
   // blocks
   ////////////////////

   inst_rom #(
      .ROM_DEPTH_LOG2(ROM_DEPTH_LOG2)
   ) rom_i (
      .clk       (clk),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data),
      .rd_pc     (fetch_pc),
      .inst0     (inst0),
      .inst1     (inst1),
      .inst2     (inst2),
      .inst3     (inst3)
   );

   branch_predictor #(
      .BPRED_INDEX_BITS(BPRED_INDEX_BITS)
   ) bpred_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .pc            (fetch_pc),
      .first_slot    (first_slot),
      .second_slot   (second_slot),
      .resolve_valid (resolve_valid),
      .resolve_pc    (resolve_pc),
      .resolve_taken (resolve_taken),
      .pred          (pred)
   );

   branch_handler handler_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .pc            (fetch_pc),
      .inst0         (inst0),
      .inst1         (inst1),
      .inst2         (inst2),
      .inst3         (inst3),
      .stall_jump    (stall_jump),
      .stall_fetch   (stall_fetch),
      .pred          (pred),
      .commit_strobe (commit_strobe),
      .mispred_two   (mispred_two),
      .first_slot    (first_slot),
      .second_slot   (second_slot),
      .update_bpred  (update_bpred),
      .slot_inst0    (slot_inst0),
      .slot_inst1    (slot_inst1),
      .slot_inst2    (slot_inst2),
      .slot_inst3    (slot_inst3),
      .imm_jump      (imm_jump),
      .pc_step       (pc_step),
      .taken_valid   (taken_valid),
      .taken_slot    (taken_slot),
      .taken_inst    (taken_inst)
   );

   fetch_pc_gen pc_gen_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .pc_step        (pc_step),
      .taken_valid    (taken_valid),
      .taken_slot     (taken_slot),
      .taken_inst     (taken_inst),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .pc             (fetch_pc)
   );

endmodule

// ==== rtl/inst_rom.sv ====
`timescale 1ns/10ps

module inst_rom #(
   parameter int ROM_DEPTH_LOG2 = 8
) (
   input  logic             clk,
   input  logic             load_en,
   input  fetch_pkg::pc_t   load_addr,
   input  fetch_pkg::inst_t load_data,
   input  fetch_pkg::pc_t   rd_pc,
   output fetch_pkg::inst_t inst0,
   output fetch_pkg::inst_t inst1,
   output fetch_pkg::inst_t inst2,
   output fetch_pkg::inst_t inst3
);

   localparam int DEPTH = 1 << ROM_DEPTH_LOG2;

   typedef logic [ROM_DEPTH_LOG2-1:0] addr_t;

   // program storage, no reset
   fetch_pkg::inst_t mem [DEPTH];

   addr_t addr0;
   addr_t addr1;
   addr_t addr2;
   addr_t addr3;

   // load port, one word per edge
   always_ff @(posedge clk) begin
      if (load_en) begin
         mem[addr_t'(load_addr)] <= load_data;
      end
   end

   // four consecutive words, address wraps at top of memory
   assign addr0 = addr_t'(rd_pc);
   assign addr1 = addr0 + addr_t'(1);
   assign addr2 = addr0 + addr_t'(2);
   assign addr3 = addr0 + addr_t'(3);

   // asynchronous read
   assign inst0 = mem[addr0];
   assign inst1 = mem[addr1];
   assign inst2 = mem[addr2];
   assign inst3 = mem[addr3];

endmodule

// ==== verilog.f ====
rtl/fetch_pkg.sv
rtl/inst_rom.sv
rtl/branch_predictor.sv
rtl/branch_handler.sv
rtl/fetch_pc_gen.sv
rtl/fetch_unit.sv
bench/fetch_unit_assertions.sv
bench/fetch_unit_tb.sv
